/* hw/jtag_consts.svh */
////////////////////////////////////////
// JTAG TAP widths, IDCODE value and
// instruction codes
////////////////////////////////////////
`ifndef JTAG_CONSTS_SVH
`define JTAG_CONSTS_SVH

// Instruction register width
`define JTAG_IR_LEN 5

// Device identifier, bit 0 is always 1 per IEEE 1149.1
`define JTAG_IDCODE 32'h1B3A_50C7

// Instruction codes, any unlisted code falls back to BYPASS
`define JTAG_INSN_IDCODE 5'd1
`define JTAG_INSN_USER   5'd8
`define JTAG_INSN_SYSRST 5'd10
`define JTAG_INSN_BYPASS 5'd31

// User data register width
`define JTAG_USER_W 32

`endif

/* hw/jtag_pkg.sv */
////////////////////////////////////////
// TAP state encoding and the strobe
// bundle shared by the TAP modules
////////////////////////////////////////
package jtag_pkg;

    // Sixteen TAP states, IR column sits at 9 and above
    typedef enum logic [3:0] {
        TAP_RESET      = 4'd0,
        TAP_IDLE       = 4'd1,
        TAP_SELECT_DR  = 4'd2,
        TAP_CAPTURE_DR = 4'd3,
        TAP_SHIFT_DR   = 4'd4,
        TAP_EXIT1_DR   = 4'd5,
        TAP_PAUSE_DR   = 4'd6,
        TAP_EXIT2_DR   = 4'd7,
        TAP_UPDATE_DR  = 4'd8,
        TAP_SELECT_IR  = 4'd9,
        TAP_CAPTURE_IR = 4'd10,
        TAP_SHIFT_IR   = 4'd11,
        TAP_EXIT1_IR   = 4'd12,
        TAP_PAUSE_IR   = 4'd13,
        TAP_EXIT2_IR   = 4'd14,
        TAP_UPDATE_IR  = 4'd15
    } tap_state_t;

    // Per-edge strobes, one clk wide, plus the shifting level
    typedef struct packed {
        logic tck_fall;
        logic capture_dr;
        logic shift_dr;
        logic update_dr;
        logic capture_ir;
        logic shift_ir;
        logic update_ir;
        logic tlr;
        logic shifting;
    } tap_ctrl_t;

endpackage

/* hw/jtag_tap_ctrl.sv */
////////////////////////////////////////
// TCK synchronizer, edge detector and
// sixteen-state TAP FSM
////////////////////////////////////////
`timescale 1ns/1ps

module jtag_tap_ctrl
    import jtag_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      tck_i,
    input  logic      tms_i,
    output tap_ctrl_t ctrl_o,
    output logic      ir_path_o
);

    ////////////////////////////////////////
    // TCK oversampling
    ////////////////////////////////////////

    // Two sync flops, then one history flop for edge detect
    logic [1:0] tck_sync;
    logic       tck_hist;
    logic       tck_rise;
    logic       tck_fall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tck_sync <= 2'b00;
            tck_hist <= 1'b0;
        end else begin
            tck_sync <= {tck_sync[0], tck_i};
            tck_hist <= tck_sync[1];
        end
    end

    // Edge strobes, one clk each
    assign tck_rise = tck_sync[1] & ~tck_hist;
    assign tck_fall = ~tck_sync[1] & tck_hist;

    ////////////////////////////////////////
    // TAP state machine
    ////////////////////////////////////////

    tap_state_t state_q;
    tap_state_t state_d;

    // Standard 1149.1 transitions, TMS is settled well before the rise
    always_comb begin
        case (state_q)
            TAP_RESET:      state_d = tms_i ? TAP_RESET     : TAP_IDLE;
            TAP_IDLE:       state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
            // DR column
            TAP_SELECT_DR:  state_d = tms_i ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: state_d = tms_i ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_SHIFT_DR:   state_d = tms_i ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
            TAP_EXIT1_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR:   state_d = tms_i ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
            TAP_EXIT2_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR:  state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
            // IR column
            TAP_SELECT_IR:  state_d = tms_i ? TAP_RESET     : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: state_d = tms_i ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_SHIFT_IR:   state_d = tms_i ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
            TAP_EXIT1_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR:   state_d = tms_i ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
            TAP_EXIT2_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR:  state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
            default:        state_d = TAP_RESET;
        endcase
    end

    // State only moves on a detected TCK rise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= TAP_IDLE;
        end else if (tck_rise) begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////
    // Strobe generation
    ////////////////////////////////////////

    // Action of the current state fires with the rise that leaves it
    always_comb begin
        ctrl_o          = '0;
        ctrl_o.tck_fall = tck_fall;
        ctrl_o.shifting = (state_q == TAP_SHIFT_DR) || (state_q == TAP_SHIFT_IR);
        if (tck_rise) begin
            case (state_q)
                TAP_RESET:      ctrl_o.tlr        = 1'b1;
                TAP_CAPTURE_DR: ctrl_o.capture_dr = 1'b1;
                TAP_SHIFT_DR:   ctrl_o.shift_dr   = 1'b1;
                TAP_UPDATE_DR:  ctrl_o.update_dr  = 1'b1;
                TAP_CAPTURE_IR: ctrl_o.capture_ir = 1'b1;
                TAP_SHIFT_IR:   ctrl_o.shift_ir   = 1'b1;
                TAP_UPDATE_IR:  ctrl_o.update_ir  = 1'b1;
                default:        ;
            endcase
        end
    end

    // IR column is SelectIr through UpdateIr
    assign ir_path_o = (state_q >= TAP_SELECT_IR);

    // Register actions never overlap, so IR and DR logic can act blindly
    a_one_action: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ctrl_o.capture_dr, ctrl_o.shift_dr, ctrl_o.update_dr,
                  ctrl_o.capture_ir, ctrl_o.shift_ir, ctrl_o.update_ir, ctrl_o.tlr}))
        else $error("more than one TAP action strobe high");

endmodule

/* hw/jtag_ir.sv */
////////////////////////////////////////
// Instruction shift register and
// update latch
////////////////////////////////////////
`timescale 1ns/1ps
`include "jtag_consts.svh"

module jtag_ir
    import jtag_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tdi_i,
    input  tap_ctrl_t               ctrl_i,
    output logic [`JTAG_IR_LEN-1:0] ir_o,
    output logic                    ir_so_o
);

    // Shift stage, separate from the latched instruction
    logic [`JTAG_IR_LEN-1:0] ir_sr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_sr <= `JTAG_INSN_IDCODE;
            ir_o  <= `JTAG_INSN_IDCODE;
        end else if (ctrl_i.tlr) begin
            // Test logic reset falls back to IDCODE
            ir_sr <= `JTAG_INSN_IDCODE;
            ir_o  <= `JTAG_INSN_IDCODE;
        end else begin
            // Capture pattern, low two bits must read 01
            if (ctrl_i.capture_ir) begin
                ir_sr <= {{(`JTAG_IR_LEN-2){1'b0}}, 2'b01};
            end
            // TDI enters at the MSB, LSB goes out first
            if (ctrl_i.shift_ir) begin
                ir_sr <= {tdi_i, ir_sr[`JTAG_IR_LEN-1:1]};
            end
            // New instruction takes effect here
            if (ctrl_i.update_ir) begin
                ir_o <= ir_sr;
            end
        end
    end

    assign ir_so_o = ir_sr[0];

    // Instruction must hold steady through a whole DR scan
    a_ir_stable: assert property (@(posedge clk)
        (rst_n && !ctrl_i.update_ir && !ctrl_i.tlr) |=> $stable(ir_o))
        else $error("instruction changed outside update_ir or tlr");

endmodule

/* hw/jtag_dr_bank.sv */
////////////////////////////////////////
// BYPASS, IDCODE, USER and SYSRST data
// registers with serial output select
////////////////////////////////////////
`timescale 1ns/1ps
`include "jtag_consts.svh"

module jtag_dr_bank
    import jtag_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tdi_i,
    input  tap_ctrl_t               ctrl_i,
    input  logic [`JTAG_IR_LEN-1:0] ir_i,
    input  logic [`JTAG_USER_W-1:0] user_rdata_i,
    output logic [`JTAG_USER_W-1:0] user_wdata_o,
    output logic                    user_wr_o,
    output logic                    sys_rst_n_o,
    output logic                    dr_so_o
);

    ////////////////////////////////////////
    // Instruction decode
    ////////////////////////////////////////

    logic sel_idcode;
    logic sel_user;
    logic sel_sysrst;
    logic sel_bypass;

    always_comb begin
        sel_idcode = 1'b0;
        sel_user   = 1'b0;
        sel_sysrst = 1'b0;
        sel_bypass = 1'b0;
        case (ir_i)
            `JTAG_INSN_IDCODE: sel_idcode = 1'b1;
            `JTAG_INSN_USER:   sel_user   = 1'b1;
            `JTAG_INSN_SYSRST: sel_sysrst = 1'b1;
            `JTAG_INSN_BYPASS: sel_bypass = 1'b1;
            // Unknown codes act as BYPASS
            default:           sel_bypass = 1'b1;
        endcase
    end

    ////////////////////////////////////////
    // Shift registers
    ////////////////////////////////////////

    logic                    bypass_q;
    logic [31:0]             idcode_sr;
    logic [`JTAG_USER_W-1:0] user_sr;
    logic                    sysrst_sr;
    logic                    sysrst_q;

    // Only the selected register reacts, TDI in at MSB
    always_ff @(posedge clk) begin
        if (sel_bypass && ctrl_i.capture_dr) bypass_q <= 1'b0;
        if (sel_bypass && ctrl_i.shift_dr) bypass_q <= tdi_i;
        if (sel_idcode && ctrl_i.capture_dr) idcode_sr <= `JTAG_IDCODE;
        if (sel_idcode && ctrl_i.shift_dr) idcode_sr <= {tdi_i, idcode_sr[31:1]};
        if (sel_user && ctrl_i.capture_dr) user_sr <= user_rdata_i;
        if (sel_user && ctrl_i.shift_dr) user_sr <= {tdi_i, user_sr[`JTAG_USER_W-1:1]};
        // Reads back the live reset request
        if (sel_sysrst && ctrl_i.capture_dr) sysrst_sr <= sysrst_q;
        if (sel_sysrst && ctrl_i.shift_dr) sysrst_sr <= tdi_i;
    end

    ////////////////////////////////////////
    // Update side
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            user_wr_o <= 1'b0;
            sysrst_q  <= 1'b0;
        end else begin
            // Single-cycle write pulse toward the system
            user_wr_o <= sel_user && ctrl_i.update_dr;
            if (ctrl_i.tlr) begin
                sysrst_q <= 1'b0;
            end else if (sel_sysrst && ctrl_i.update_dr) begin
                sysrst_q <= sysrst_sr;
            end
        end
    end

    // Write data follows the pulse
    always_ff @(posedge clk) begin
        if (sel_user && ctrl_i.update_dr) user_wdata_o <= user_sr;
    end

    assign sys_rst_n_o = ~sysrst_q;

    // Serial out is the LSB of whichever register is selected
    assign dr_so_o = sel_idcode ? idcode_sr[0] :
                     sel_user   ? user_sr[0]   :
                     sel_sysrst ? sysrst_sr    : bypass_q;

    // One write per UpdateDr visit
    a_wr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        user_wr_o |=> !user_wr_o)
        else $error("user_wr_o high for two cycles");

endmodule

/* hw/jtag_tdo_out.sv */
////////////////////////////////////////
// TDO source select and falling-edge
// output register
////////////////////////////////////////
`timescale 1ns/1ps

module jtag_tdo_out
    import jtag_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  tap_ctrl_t ctrl_i,
    input  logic      ir_path_i,
    input  logic      ir_so_i,
    input  logic      dr_so_i,
    output logic      tdo_o,
    output logic      tdo_oe_o
);

    // Data is driven on TCK fall so the host samples it on the next rise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tdo_o    <= 1'b0;
            tdo_oe_o <= 1'b0;
        end else if (ctrl_i.tck_fall) begin
            // IR column drives the instruction register bit
            tdo_o    <= ir_path_i ? ir_so_i : dr_so_i;
            // Pad enabled only while a Shift state is active
            tdo_oe_o <= ctrl_i.shifting;
        end
    end

endmodule

/* hw/jtag_top.sv */
////////////////////////////////////////
// JTAG TAP top, wires the controller,
// IR, DR bank and TDO stage together
////////////////////////////////////////
`timescale 1ns/1ps
`include "jtag_consts.svh"

module jtag_top
    import jtag_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    // JTAG pads
    input  logic                    tck_i,
    input  logic                    tms_i,
    input  logic                    tdi_i,
    output logic                    tdo_o,
    output logic                    tdo_oe_o,
    // System side
    input  logic [`JTAG_USER_W-1:0] user_rdata_i,
    output logic [`JTAG_USER_W-1:0] user_wdata_o,
    output logic                    user_wr_o,
    output logic                    sys_rst_n_o
);

    // Strobes fan out from the controller
    tap_ctrl_t               ctrl;
    logic                    ir_path;
    logic [`JTAG_IR_LEN-1:0] ir;
    logic                    ir_so;
    logic                    dr_so;

    jtag_tap_ctrl jtag_tap_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .tck_i     (tck_i),
        .tms_i     (tms_i),
        .ctrl_o    (ctrl),
        .ir_path_o (ir_path)
    );

    jtag_ir jtag_ir_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .tdi_i   (tdi_i),
        .ctrl_i  (ctrl),
        .ir_o    (ir),
        .ir_so_o (ir_so)
    );

    jtag_dr_bank jtag_dr_bank_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .tdi_i        (tdi_i),
        .ctrl_i       (ctrl),
        .ir_i         (ir),
        .user_rdata_i (user_rdata_i),
        .user_wdata_o (user_wdata_o),
        .user_wr_o    (user_wr_o),
        .sys_rst_n_o  (sys_rst_n_o),
        .dr_so_o      (dr_so)
    );

    jtag_tdo_out jtag_tdo_out_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl_i    (ctrl),
        .ir_path_i (ir_path),
        .ir_so_i   (ir_so),
        .dr_so_i   (dr_so),
        .tdo_o     (tdo_o),
        .tdo_oe_o  (tdo_oe_o)
    );

endmodule

/* verif/jtag_tb.sv */
////////////////////////////////////////
// Self-checking testbench for the JTAG
// TAP with bit-banged tck and LFSR data
////////////////////////////////////////
`timescale 1ns/1ps
`include "jtag_consts.svh"

module jtag_tb;

    logic        clk;
    logic        rst_n;
    logic        tck_i;
    logic        tms_i;
    logic        tdi_i;
    logic        tdo_o;
    logic        tdo_oe_o;
    logic [31:0] user_rdata_i;
    logic [31:0] user_wdata_o;
    logic        user_wr_o;
    logic        sys_rst_n_o;

    // Galois LFSR state, seed 87
    logic [15:0] lfsr = 16'd87;
    // Write pulse counter and last written word
    int          wr_count = 0;
    logic [31:0] wr_data;
    // Reset request as the host expects it
    logic        sysrst_model = 1'b0;
    // Pending comparisons, drained by the compare process
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    string       name_q[$];

    jtag_top jtag_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .tck_i        (tck_i),
        .tms_i        (tms_i),
        .tdi_i        (tdi_i),
        .tdo_o        (tdo_o),
        .tdo_oe_o     (tdo_oe_o),
        .user_rdata_i (user_rdata_i),
        .user_wdata_o (user_wdata_o),
        .user_wr_o    (user_wr_o),
        .sys_rst_n_o  (sys_rst_n_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////
    // Reference model and random data
    ////////////////////////////////////////

    // Bits out of a DR scan, captured value first, then TDI delayed by the width
    function automatic logic [31:0] ref_dr_out(input logic [4:0] insn, input logic [31:0] din,
                                               input int n, input logic [31:0] rdata,
                                               input logic rst_req);
        logic [31:0] cap;
        int          w;
        logic [31:0] r;
        case (insn)
            `JTAG_INSN_IDCODE: begin
                cap = `JTAG_IDCODE;
                w   = 32;
            end
            `JTAG_INSN_USER: begin
                cap = rdata;
                w   = `JTAG_USER_W;
            end
            `JTAG_INSN_SYSRST: begin
                cap = {31'b0, rst_req};
                w   = 1;
            end
            // BYPASS and unknown codes capture a single 0
            default: begin
                cap = 32'b0;
                w   = 1;
            end
        endcase
        r = '0;
        for (int i = 0; i < n; i++) begin
            if (i < w) r[i] = cap[i];
            else r[i] = din[i - w];
        end
        return r;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    ////////////////////////////////////////
    // Checking
    ////////////////////////////////////////

    task automatic expect_val(input string name, input logic [31:0] e, input logic [31:0] a);
        name_q.push_back(name);
        exp_q.push_back(e);
        act_q.push_back(a);
    endtask

    always @(posedge clk) begin : compare
        logic [31:0] e;
        logic [31:0] a;
        string       n;
        while (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            a = act_q.pop_front();
            n = name_q.pop_front();
            assert (e === a) else begin
                $display("[ERROR] %s: expected %h, actual %h", n, e, a);
                $display("TEST FAIL");
                $fatal(1, "mismatch in %s", n);
            end
        end
    end

    // Counts write pulses toward the system
    always @(posedge clk) begin
        if (rst_n && user_wr_o) begin
            wr_count <= wr_count + 1;
            wr_data  <= user_wdata_o;
        end
    end

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    endtask

    ////////////////////////////////////////
    // TCK bit-banging
    ////////////////////////////////////////

    task automatic wait_clks(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Low phase, sample just before the rise, then high phase
    task automatic tck_bit(input logic tms, input logic tdi, output logic so, output logic oe);
        tms_i = tms;
        tdi_i = tdi;
        wait_clks(4);
        so    = tdo_o;
        oe    = tdo_oe_o;
        tck_i = 1'b1;
        wait_clks(4);
        tck_i = 1'b0;
    endtask

    // From a Shift state out through Exit1 and Update back to Idle
    task automatic shift_bits(input logic [31:0] din, input int n, output logic [31:0] dout);
        logic so;
        logic oe;
        dout = '0;
        for (int i = 0; i < n; i++) begin
            tck_bit(i == n - 1, din[i], so, oe);
            dout[i] = so;
            expect_val("tdo_oe during shift", 32'd1, {31'b0, oe});
        end
        tck_bit(1'b1, 1'b0, so, oe);
        expect_val("tdo_oe after shift", 32'd0, {31'b0, oe});
        tck_bit(1'b0, 1'b0, so, oe);
    endtask

    task automatic dr_scan(input logic [31:0] din, input int n, output logic [31:0] dout);
        logic so;
        logic oe;
        tck_bit(1'b1, 1'b0, so, oe);
        expect_val("tdo_oe before DR shift", 32'd0, {31'b0, oe});
        tck_bit(1'b0, 1'b0, so, oe);
        tck_bit(1'b0, 1'b0, so, oe);
        expect_val("tdo_oe in CaptureDr", 32'd0, {31'b0, oe});
        shift_bits(din, n, dout);
    endtask

    task automatic ir_scan(input logic [4:0] insn, output logic [31:0] dout);
        logic so;
        logic oe;
        tck_bit(1'b1, 1'b0, so, oe);
        tck_bit(1'b1, 1'b0, so, oe);
        tck_bit(1'b0, 1'b0, so, oe);
        tck_bit(1'b0, 1'b0, so, oe);
        shift_bits({27'b0, insn}, `JTAG_IR_LEN, dout);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin : stimulus
        logic [31:0] din;
        logic [31:0] dout;
        logic [31:0] rd;
        logic        so;
        logic        oe;
        int          wr_before;
        int          t;
        rst_n        = 1'b0;
        tck_i        = 1'b0;
        tms_i        = 1'b0;
        tdi_i        = 1'b0;
        user_rdata_i = '0;
        wait_clks(16);
        rst_n = 1'b1;
        wait_clks(2);
        expect_val("sys_rst_n after reset", 32'd1, {31'b0, sys_rst_n_o});

        // IDCODE is the reset instruction
        dr_scan(32'h0, 32, dout);
        expect_val("idcode after reset", ref_dr_out(`JTAG_INSN_IDCODE, 0, 32, 0, 0), dout);

        ir_scan(`JTAG_INSN_BYPASS, dout);
        expect_val("ir capture", 32'b00001, dout);

        take_bits(16, din);
        dr_scan(din, 16, dout);
        expect_val("bypass", ref_dr_out(`JTAG_INSN_BYPASS, din, 16, 0, 0), dout);
        ir_scan(5'd5, dout);
        take_bits(16, din);
        dr_scan(din, 16, dout);
        expect_val("unlisted code", ref_dr_out(5'd5, din, 16, 0, 0), dout);

        // USER read and write
        ir_scan(`JTAG_INSN_USER, dout);
        take_bits(32, rd);
        user_rdata_i = rd;
        take_bits(32, din);
        wr_before = wr_count;
        dr_scan(din, 32, dout);
        expect_val("user read", ref_dr_out(`JTAG_INSN_USER, din, 32, rd, 0), dout);
        t = 0;
        while (wr_count == wr_before) begin
            if (t >= 100) report_timeout("user_wr_o");
            wait_clks(1);
            t++;
        end
        wait_clks(8);
        expect_val("user_wr pulse count", 32'd1, 32'(wr_count - wr_before));
        expect_val("user wdata", din, wr_data);

        // System reset set then cleared
        ir_scan(`JTAG_INSN_SYSRST, dout);
        dr_scan(32'h1, 1, dout);
        expect_val("sysrst readback", ref_dr_out(`JTAG_INSN_SYSRST, 1, 1, 0, sysrst_model), dout);
        sysrst_model = 1'b1;
        expect_val("sys_rst_n set", 32'd0, {31'b0, sys_rst_n_o});
        dr_scan(32'h0, 1, dout);
        expect_val("sysrst readback", ref_dr_out(`JTAG_INSN_SYSRST, 0, 1, 0, sysrst_model), dout);
        sysrst_model = 1'b0;
        expect_val("sys_rst_n cleared", 32'd1, {31'b0, sys_rst_n_o});

        // Five TMS-high rises reach Test-Logic-Reset from anywhere
        ir_scan(`JTAG_INSN_SYSRST, dout);
        dr_scan(32'h1, 1, dout);
        sysrst_model = 1'b1;
        expect_val("sys_rst_n before tlr", {31'b0, ~sysrst_model}, {31'b0, sys_rst_n_o});
        ir_scan(`JTAG_INSN_USER, dout);
        repeat (5) tck_bit(1'b1, 1'b0, so, oe);
        tck_bit(1'b0, 1'b0, so, oe);
        // Test-Logic-Reset drops the reset request
        sysrst_model = 1'b0;
        dr_scan(32'h0, 32, dout);
        expect_val("idcode after tlr", ref_dr_out(`JTAG_INSN_IDCODE, 0, 32, 0, 0), dout);
        expect_val("sys_rst_n after tlr", {31'b0, ~sysrst_model}, {31'b0, sys_rst_n_o});

        // Let the compare process empty its queue
        t = 0;
        while (exp_q.size() > 0) begin
            if (t >= 100) report_timeout("the compare queue to drain");
            wait_clks(1);
            t++;
        end
        wait_clks(2);
        $display("TEST PASS");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hw
hw/jtag_pkg.sv
hw/jtag_tap_ctrl.sv
hw/jtag_ir.sv
hw/jtag_dr_bank.sv
hw/jtag_tdo_out.sv
hw/jtag_top.sv
verif/jtag_tb.sv
